// ==== source/vec_dispatch_config.svh ====
`ifndef VEC_DISPATCH_CONFIG_SVH
`define VEC_DISPATCH_CONFIG_SVH

// queue depth, the head is always the highest slot
`define VD_NUM_ENTRIES 4

// elements advanced each time the head rotates
`define VD_LANES 2

// element indices and counts share this width
`define VD_ELM_WIDTH 8

`define VD_INSTR_WIDTH 32

`endif

// ==== source/vec_types_pkg.sv ====
`include "vec_dispatch_config.svh"

package vec_types_pkg;

    // instruction layout, msb first
    //   [31:26] opcode  [25:21] dst reg  [20:16] src reg
    //   [15:8]  write offset  [7:0] length in elements
    typedef logic [`VD_INSTR_WIDTH-1:0] instr_word_t;

    typedef logic [`VD_ELM_WIDTH-1:0] elm_idx_t;   // rdelm and wrelm
    typedef logic [`VD_ELM_WIDTH-1:0] elm_count_t; // elements completed so far

    typedef logic [5:0] opcode_t;
    typedef logic [4:0] vreg_t;

endpackage

// ==== source/vec_ctrl_pkg.sv ====
package vec_ctrl_pkg;

    import vec_types_pkg::*;

    // the only codes decode accepts
    typedef enum opcode_t {
        VADD = 6'h01,
        VSUB = 6'h02,
        VMUL = 6'h03,
        VLD  = 6'h08,
        VST  = 6'h09
    } vec_op_e;

    // busy means the queue may still hold a live entry
    typedef enum logic {
        SEQ_EMPTY = 1'b0,
        SEQ_BUSY  = 1'b1
    } seq_state_e;

endpackage

// ==== source/vec_elm_shifter.sv ====
`timescale 1ns/1ps

module vec_elm_shifter #(
    parameter int num_entries = 4,
    parameter int width       = 32
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         shift,
    input  logic [num_entries-1:0]       squash,   // indexed by destination slot
    input  logic [width-1:0]             shift_in,
    output logic [num_entries*width-1:0] slots
);

    logic [num_entries*width-1:0] moved;

    always_comb
    begin
        // every slot moves up one, the top slot falls off
        moved = {slots[(num_entries-1)*width-1:0], shift_in};
        for (int i = 0; i < num_entries; i++)
        begin
            if (squash[i])
                moved[i*width +: width] = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            slots <= '0;
        else if (shift)
            slots <= moved;
    end

endmodule

// ==== source/vec_dispatch_counter_field.sv ====
`timescale 1ns/1ps
`include "vec_dispatch_config.svh"

module vec_dispatch_counter_field
    import vec_types_pkg::*;
(
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              shift,
    input  logic                              rotate,
    input  logic [`VD_NUM_ENTRIES-1:0]        increment,
    input  elm_count_t                        shift_in,
    output elm_count_t [`VD_NUM_ENTRIES-1:0]  slots
);

    elm_count_t [`VD_NUM_ENTRIES-1:0] summed;
    logic [`VD_ELM_WIDTH:0]           wide_sum [`VD_NUM_ENTRIES];
    elm_count_t                       slot0_in;

    //////////////////////////////////////////////////
    // saturating add on the selected slots

    always_comb
    begin
        for (int i = 0; i < `VD_NUM_ENTRIES; i++)
        begin
            wide_sum[i] = {1'b0, slots[i]} + (`VD_ELM_WIDTH+1)'(`VD_LANES);
            if (!increment[i])
                summed[i] = slots[i];
            else if (wide_sum[i][`VD_ELM_WIDTH])
                summed[i] = '1;  // carry out means we clamp at all ones
            else
                summed[i] = wide_sum[i][`VD_ELM_WIDTH-1:0];
        end
    end

    //////////////////////////////////////////////////
    // ring update

    assign slot0_in = rotate ? summed[`VD_NUM_ENTRIES-1] : shift_in;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            slots <= '0;
        else if (shift)
            slots <= {summed[`VD_NUM_ENTRIES-2:0], slot0_in};
    end

endmodule

// ==== source/vec_dispatch_queue.sv ====
`timescale 1ns/1ps
`include "vec_dispatch_config.svh"

module vec_dispatch_queue
    import vec_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       shift,
    input  logic                       rotate,     // only meaningful with shift high
    input  logic [`VD_NUM_ENTRIES-1:0] increment,
    input  instr_word_t                new_instr,
    input  elm_idx_t                   new_wrelm,
    input  logic                       new_valid,
    output instr_word_t                head_instr,
    output logic                       head_first,
    output elm_idx_t                   head_rdelm,
    output elm_idx_t                   head_wrelm,
    output elm_count_t                 head_count,
    output logic                       head_valid,
    output logic                       any_valid
);

    localparam int head_slot = `VD_NUM_ENTRIES - 1;

    logic [`VD_NUM_ENTRIES*`VD_INSTR_WIDTH-1:0] instr_slots;
    logic [`VD_NUM_ENTRIES-1:0]                 first_slots;
    logic [`VD_NUM_ENTRIES-1:0]                 valid_slots;
    elm_idx_t [`VD_NUM_ENTRIES-1:0]             rdelm_slots;
    elm_idx_t [`VD_NUM_ENTRIES-1:0]             wrelm_slots;
    elm_count_t [`VD_NUM_ENTRIES-1:0]           count_slots;
    instr_word_t                                instr_in;
    logic                                       first_in;
    logic                                       valid_in;
    logic [`VD_NUM_ENTRIES-1:0]                 first_squash;

    //////////////////////////////////////////////////
    // plain rings, fed back from the head on rotate

    assign instr_in = rotate ? head_instr : new_instr;
    assign first_in = rotate ? first_slots[head_slot] : new_valid;
    assign valid_in = rotate ? valid_slots[head_slot] : new_valid;

    // the head lands in slot 0 on a rotate and loses its first flag there
    assign first_squash = {increment[head_slot-1:0], increment[head_slot]};

    vec_elm_shifter #(.num_entries(`VD_NUM_ENTRIES), .width(`VD_INSTR_WIDTH)) u_instr (
        .clk      (clk),
        .resetn   (resetn),
        .shift    (shift),
        .squash   ('0),
        .shift_in (instr_in),
        .slots    (instr_slots)
    );

    vec_elm_shifter #(.num_entries(`VD_NUM_ENTRIES), .width(1)) u_first (
        .clk      (clk),
        .resetn   (resetn),
        .shift    (shift),
        .squash   (first_squash),
        .shift_in (first_in),
        .slots    (first_slots)
    );

    vec_elm_shifter #(.num_entries(`VD_NUM_ENTRIES), .width(1)) u_valid (
        .clk      (clk),
        .resetn   (resetn),
        .shift    (shift),
        .squash   ('0),
        .shift_in (valid_in),
        .slots    (valid_slots)
    );

    //////////////////////////////////////////////////
    // counter rings, a new entry starts reading at element 0

    vec_dispatch_counter_field u_rdelm (
        .clk       (clk),
        .resetn    (resetn),
        .shift     (shift),
        .rotate    (rotate),
        .increment (increment),
        .shift_in  ('0),
        .slots     (rdelm_slots)
    );

    vec_dispatch_counter_field u_wrelm (
        .clk       (clk),
        .resetn    (resetn),
        .shift     (shift),
        .rotate    (rotate),
        .increment (increment),
        .shift_in  (new_wrelm),
        .slots     (wrelm_slots)
    );

    vec_dispatch_counter_field u_count (
        .clk       (clk),
        .resetn    (resetn),
        .shift     (shift),
        .rotate    (rotate),
        .increment (increment),
        .shift_in  ('0),
        .slots     (count_slots)
    );

    assign head_instr = instr_slots[head_slot*`VD_INSTR_WIDTH +: `VD_INSTR_WIDTH];
    assign head_first = first_slots[head_slot];
    assign head_valid = valid_slots[head_slot];
    assign head_rdelm = rdelm_slots[head_slot];
    assign head_wrelm = wrelm_slots[head_slot];
    assign head_count = count_slots[head_slot];
    assign any_valid  = |valid_slots;

endmodule

// ==== source/vec_instr_decode.sv ====
`timescale 1ns/1ps

module vec_instr_decode
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic        issue,
    input  instr_word_t issue_instr,
    output logic        entry_ok,
    output logic        illegal,
    output elm_idx_t    new_wrelm
);

    opcode_t    opcode;
    elm_count_t length;
    logic       op_known;

    assign opcode = issue_instr[31:26];
    assign length = issue_instr[7:0];

    always_comb
    begin
        case (opcode)
            VADD, VSUB, VMUL, VLD, VST:
                op_known = 1'b1;
            default:
                op_known = 1'b0;
        endcase
    end

    // a zero length op would never finish a rotate, so it is refused too
    assign entry_ok = op_known && (length != '0);
    assign illegal  = issue && !entry_ok;

    assign new_wrelm = issue_instr[15:8];  // writes start at the offset

endmodule

// ==== source/vec_issue_sequencer.sv ====
`timescale 1ns/1ps
`include "vec_dispatch_config.svh"

module vec_issue_sequencer
    import vec_ctrl_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       issue,
    input  logic                       entry_ok,
    input  logic                       head_valid,
    input  logic                       finished,
    input  logic                       any_valid,
    output logic                       shift,
    output logic                       rotate,
    output logic [`VD_NUM_ENTRIES-1:0] increment,
    output logic                       new_valid,
    output logic                       stall,
    output logic                       dropped,
    output logic                       exec_valid
);

    seq_state_e state;
    seq_state_e state_next;
    logic       do_rotate;
    logic       do_insert;
    logic       do_bubble;

    //////////////////////////////////////////////////
    // action select

    always_comb
    begin
        do_rotate = 1'b0;
        do_bubble = 1'b0;
        case (state)
            SEQ_EMPTY:
            begin
                // queue is known empty here, only an insert can happen
                do_insert  = issue && entry_ok;
                state_next = do_insert ? SEQ_BUSY : SEQ_EMPTY;
            end
            default:
            begin
                do_rotate = head_valid && !finished;
                do_insert = !do_rotate && issue && entry_ok;
                do_bubble = !do_rotate && !do_insert && any_valid;
                // a bubble may drain the last entry, the next hold catches that
                state_next = (do_rotate || do_insert || do_bubble) ? SEQ_BUSY : SEQ_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= SEQ_EMPTY;
        else
            state <= state_next;
    end

    //////////////////////////////////////////////////
    // queue control and status

    assign shift      = do_rotate || do_insert || do_bubble;
    assign rotate     = do_rotate;
    assign new_valid  = do_insert;
    assign increment  = {do_rotate, {(`VD_NUM_ENTRIES-1){1'b0}}};  // head slot only
    assign exec_valid = do_rotate;  // one element op per rotate of a live head

    assign stall   = do_rotate;
    assign dropped = issue && stall;

endmodule

// ==== source/vec_dispatch_result.sv ====
`timescale 1ns/1ps

module vec_dispatch_result
    import vec_types_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  instr_word_t head_instr,
    input  logic        head_valid,
    input  elm_idx_t    head_wrelm,
    input  elm_count_t  head_count,
    input  logic        shift,
    output logic        finished,
    output logic        retire_valid,
    output instr_word_t retire_instr,
    output elm_idx_t    retire_wrelm,
    output elm_count_t  retire_count
);

    elm_count_t head_length;
    logic       retire_now;

    assign head_length = head_instr[7:0];
    assign finished    = head_count >= head_length;

    // a rotate never happens on a finished head, so any shift here drops it
    assign retire_now = shift && head_valid && finished;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            retire_valid <= 1'b0;
        else
            retire_valid <= retire_now;
    end

    always_ff @(posedge clk)
    begin
        if (retire_now)
        begin
            retire_instr <= head_instr;
            retire_wrelm <= head_wrelm;
            retire_count <= head_count;
        end
    end

endmodule

// ==== source/vec_dispatch_top.sv ====
`timescale 1ns/1ps
`include "vec_dispatch_config.svh"

module vec_dispatch_top
    import vec_types_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        issue,
    input  instr_word_t issue_instr,
    output logic        stall,
    output logic        illegal,
    output logic        dropped,
    output logic        exec_valid,
    output instr_word_t exec_instr,
    output logic        exec_first,
    output elm_idx_t    exec_rdelm,
    output elm_idx_t    exec_wrelm,
    output logic        retire_valid,
    output instr_word_t retire_instr,
    output elm_idx_t    retire_wrelm,
    output elm_count_t  retire_count
);

    logic                       entry_ok;
    elm_idx_t                   new_wrelm;
    logic                       shift;
    logic                       rotate;
    logic [`VD_NUM_ENTRIES-1:0] increment;
    logic                       new_valid;
    logic                       head_valid;
    logic                       any_valid;
    logic                       finished;
    elm_count_t                 head_count;

    vec_instr_decode u_decode (
        .issue       (issue),
        .issue_instr (issue_instr),
        .entry_ok    (entry_ok),
        .illegal     (illegal),
        .new_wrelm   (new_wrelm)
    );

    // the exec fields are the head slot itself, qualified by exec_valid
    vec_dispatch_queue u_queue (
        .clk        (clk),
        .resetn     (resetn),
        .shift      (shift),
        .rotate     (rotate),
        .increment  (increment),
        .new_instr  (issue_instr),
        .new_wrelm  (new_wrelm),
        .new_valid  (new_valid),
        .head_instr (exec_instr),
        .head_first (exec_first),
        .head_rdelm (exec_rdelm),
        .head_wrelm (exec_wrelm),
        .head_count (head_count),
        .head_valid (head_valid),
        .any_valid  (any_valid)
    );

    vec_issue_sequencer u_seq (
        .clk        (clk),
        .resetn     (resetn),
        .issue      (issue),
        .entry_ok   (entry_ok),
        .head_valid (head_valid),
        .finished   (finished),
        .any_valid  (any_valid),
        .shift      (shift),
        .rotate     (rotate),
        .increment  (increment),
        .new_valid  (new_valid),
        .stall      (stall),
        .dropped    (dropped),
        .exec_valid (exec_valid)
    );

    vec_dispatch_result u_result (
        .clk          (clk),
        .resetn       (resetn),
        .head_instr   (exec_instr),
        .head_valid   (head_valid),
        .head_wrelm   (exec_wrelm),
        .head_count   (head_count),
        .shift        (shift),
        .finished     (finished),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .retire_wrelm (retire_wrelm),
        .retire_count (retire_count)
    );

endmodule

// ==== dv/vec_dispatch_tb.sv ====
`timescale 1ns/1ps
`include "vec_dispatch_config.svh"

module vec_dispatch_tb
    import vec_types_pkg::*;
    import vec_ctrl_pkg::*;
();

    localparam int num_rows = 12;
    localparam int elm_max  = (1 << `VD_ELM_WIDTH) - 1;
    localparam instr_word_t dropped_word = {opcode_t'(VADD), 5'd2, 5'd31, 8'h10, 8'd4};

    logic        clk;
    logic        resetn;
    logic        issue;
    instr_word_t issue_instr;
    logic        stall;
    logic        illegal;
    logic        dropped;
    logic        exec_valid;
    instr_word_t exec_instr;
    logic        exec_first;
    elm_idx_t    exec_rdelm;
    elm_idx_t    exec_wrelm;
    logic        retire_valid;
    instr_word_t retire_instr;
    elm_idx_t    retire_wrelm;
    elm_count_t  retire_count;

    // length kind: 0 random, 1 zero, 2 all ones, 3 one element
    opcode_t row_op       [num_rows] = '{VADD, VSUB, 6'h3f, VMUL, VLD, VADD,
                                         6'h00, VST, VSUB, VMUL, 6'h04, VLD};
    int      row_len_kind [num_rows] = '{0, 0, 0, 2, 1, 0, 0, 0, 3, 0, 0, 0};
    logic    row_legal    [num_rows] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1,
                                         1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};

    instr_word_t row_word     [num_rows];  // src reg field holds the row number
    int          row_len      [num_rows];
    int          row_off      [num_rows];
    logic        row_issued   [num_rows];
    logic        row_retired  [num_rows];
    int          row_ops_seen [num_rows];

    logic [31:0] lfsr_state;
    int          value_errors  = 0;
    int          other_errors  = 0;
    int          cycle_count   = 0;
    int          cycle_limit;
    int          legal_total   = 0;
    int          retired_total = 0;
    logic        exp_illegal;
    logic        exp_dropped;
    logic        drained;

    vec_dispatch_top u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .issue        (issue),
        .issue_instr  (issue_instr),
        .stall        (stall),
        .illegal      (illegal),
        .dropped      (dropped),
        .exec_valid   (exec_valid),
        .exec_instr   (exec_instr),
        .exec_first   (exec_first),
        .exec_rdelm   (exec_rdelm),
        .exec_wrelm   (exec_wrelm),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .retire_wrelm (retire_wrelm),
        .retire_count (retire_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic elm_idx_t clamp_elm(input int v);
        return (v > elm_max) ? elm_idx_t'(elm_max) : elm_idx_t'(v);
    endfunction

    // each rotate of the head completes VD_LANES elements
    function automatic int ops_for_len(input int len);
        return (len + `VD_LANES - 1) / `VD_LANES;
    endfunction

    function automatic int row_of(input instr_word_t w);
        int tag;
        tag = int'(w[20:16]);
        if (tag >= num_rows || !row_issued[tag])
            return -1;
        return tag;
    endfunction

    task automatic note_failure(input string what);
        other_errors++;
        $display("Failure: %s", what);
    endtask

    task automatic check_instr(input string name, input instr_word_t expected,
                               input instr_word_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_idx(input string name, input elm_idx_t expected,
                             input elm_idx_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input elm_count_t expected,
                               input elm_count_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // monitor, sampled on the rising edge

    always @(posedge clk)
    begin
        int    r;
        int    k;
        int    n;
        string tag;
        if (resetn)
        begin
            check_bit("illegal", exp_illegal, illegal);
            check_bit("dropped", exp_dropped, dropped);
            if (drained && (exec_valid || retire_valid))
                note_failure("an element op or retire appeared after everything had retired");
            if (exec_valid)
            begin
                r = row_of(exec_instr);
                if (r < 0)
                    note_failure($sformatf("element op for %h, which was never queued", exec_instr));
                else if (row_retired[r])
                    note_failure($sformatf("element op for row %0d after its retire", r));
                else
                begin
                    k   = row_ops_seen[r];
                    tag = $sformatf("row %0d op %0d", r, k);
                    check_instr({tag, " instr"}, row_word[r], exec_instr);
                    if (k >= ops_for_len(row_len[r]))
                        note_failure($sformatf("row %0d got more element ops than its length", r));
                    else
                    begin
                        check_idx({tag, " rdelm"}, clamp_elm(`VD_LANES * k), exec_rdelm);
                        check_idx({tag, " wrelm"}, clamp_elm(row_off[r] + `VD_LANES * k), exec_wrelm);
                        check_bit({tag, " first"}, k == 0, exec_first);
                    end
                    row_ops_seen[r] = k + 1;
                end
            end
            if (retire_valid)
            begin
                r = row_of(retire_instr);
                if (r < 0)
                    note_failure($sformatf("retire of %h, which was never queued", retire_instr));
                else if (row_retired[r])
                    note_failure($sformatf("row %0d retired a second time", r));
                else
                begin
                    n   = ops_for_len(row_len[r]);
                    tag = $sformatf("row %0d retire", r);
                    check_instr({tag, " instr"}, row_word[r], retire_instr);
                    check_count({tag, " count"}, clamp_elm(`VD_LANES * n), retire_count);
                    check_idx({tag, " wrelm"}, clamp_elm(row_off[r] + `VD_LANES * n), retire_wrelm);
                    if (row_ops_seen[r] != n)
                        note_failure($sformatf("row %0d retired after %0d element ops, not %0d",
                                               r, row_ops_seen[r], n));
                    row_retired[r] = 1'b1;
                    retired_total++;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run did not complete within %0d cycles", cycle_limit);
            $display("errors: %0d value, %0d other", value_errors, other_errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus

    initial
    begin
        logic [31:0] bits;
        vreg_t       dst;
        elm_idx_t    off;
        elm_count_t  len;
        int          max_len;

        resetn      = 1'b0;
        issue       = 1'b0;
        issue_instr = '0;
        exp_illegal = 1'b0;
        exp_dropped = 1'b0;
        drained     = 1'b0;
        lfsr_state  = 32'ha4ec_f0e5;
        max_len     = 0;

        for (int r = 0; r < num_rows; r++)
        begin
            take_bits(5, bits);
            dst = bits[4:0];
            take_bits(8, bits);
            off = bits[7:0];
            case (row_len_kind[r])
                1: len = 8'd0;
                2: len = 8'hff;
                3: len = 8'd1;
                default:
                begin
                    take_bits(8, bits);
                    len = (bits[7:0] == 8'd0) ? 8'd1 : bits[7:0];  // zero length has its own row
                end
            endcase
            row_word[r]     = {row_op[r], dst, 5'(r), off, len};
            row_len[r]      = int'(len);
            row_off[r]      = int'(off);
            row_issued[r]   = 1'b0;
            row_retired[r]  = 1'b0;
            row_ops_seen[r] = 0;
            if (row_legal[r])
            begin
                legal_total++;
                if (row_len[r] > max_len)
                    max_len = row_len[r];
            end
        end
        cycle_limit = 8 + num_rows * (max_len + 4 * `VD_NUM_ENTRIES) + 100;

        repeat (8) @(negedge clk);
        resetn = 1'b1;

        repeat (3)
        begin
            @(negedge clk);
            check_bit("idle stall", 1'b0, stall);
            check_bit("idle exec_valid", 1'b0, exec_valid);
            check_bit("idle retire_valid", 1'b0, retire_valid);
            check_bit("idle illegal", 1'b0, illegal);
            check_bit("idle dropped", 1'b0, dropped);
        end

        for (int r = 0; r < num_rows; r++)
        begin
            while (stall)
                @(negedge clk);
            issue         = 1'b1;
            issue_instr   = row_word[r];
            exp_illegal   = !row_legal[r];
            row_issued[r] = row_legal[r];
            @(negedge clk);
            issue       = 1'b0;
            exp_illegal = 1'b0;
        end

        // the last row is legal, so its rotates will raise stall
        while (!stall)
            @(negedge clk);
        issue       = 1'b1;
        issue_instr = dropped_word;
        exp_dropped = 1'b1;
        @(negedge clk);
        issue       = 1'b0;
        exp_dropped = 1'b0;

        while (retired_total < legal_total)
            @(negedge clk);
        drained = 1'b1;
        repeat (4 * `VD_NUM_ENTRIES) @(negedge clk);

        $display("checks finished: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
source/vec_types_pkg.sv
source/vec_ctrl_pkg.sv
source/vec_elm_shifter.sv
source/vec_dispatch_counter_field.sv
source/vec_dispatch_queue.sv
source/vec_instr_decode.sv
source/vec_issue_sequencer.sv
source/vec_dispatch_result.sv
source/vec_dispatch_top.sv
dv/vec_dispatch_tb.sv

// ==== Makefile ====
# Verilator build and run for the vector dispatcher testbench

VERILATOR ?= verilator
TOP       ?= vec_dispatch_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
